//--- common/shim_defines.svh
// lane count, lane width, port count and timestamp width macros for the ingress shim
`ifndef SHIM_DEFINES_SVH
`define SHIM_DEFINES_SVH

// ------------------------------------------------------------
// word geometry
// ------------------------------------------------------------

// lanes per input word and per output segment
`define SHIM_LANES 8

// bits per data lane
`define SHIM_LANE_W 64

// ------------------------------------------------------------
// shim size
// ------------------------------------------------------------

// ethernet port lanes served by one shim
`define SHIM_PORTS 4

// width of the start-of-frame timestamp
`define SHIM_TS_W 16

`endif

//--- common/shim_epl_pkg.sv
// input-side types: lane word, port metadata and per-port input bundle
`include "shim_defines.svh"

package shim_epl_pkg;

  // ------------------------------------------------------------
  // data lane
  // ------------------------------------------------------------

  typedef logic [`SHIM_LANE_W-1:0] epl_lane_t;

  // ------------------------------------------------------------
  // per-word metadata from the port
  // ------------------------------------------------------------

  // start and end lanes only mean something with their flags set
  typedef struct packed {
    logic                             sop;
    logic [$clog2(`SHIM_LANES)-1:0]   sop_lane;
    logic                             eop;
    logic [$clog2(`SHIM_LANES)-1:0]   eop_lane;
    logic [`SHIM_TS_W-1:0]            ts;
  } epl_md_t;

  // ------------------------------------------------------------
  // one port's input word
  // ------------------------------------------------------------

  // valid is a single-cycle strobe, there is no ready
  typedef struct packed {
    logic                             v;
    epl_md_t                          md;
    epl_lane_t [`SHIM_LANES-1:0]      lanes;
  } epl_in_t;

endpackage

//--- common/shim_pb_pkg.sv
// buffer-side types: segment metadata, output segment and control-to-datapath select
`include "shim_defines.svh"

package shim_pb_pkg;

  // ------------------------------------------------------------
  // segment metadata
  // ------------------------------------------------------------

  // cnt runs 1 to 8, so it needs one bit more than a lane index
  typedef struct packed {
    logic                             sop;
    logic                             eop;
    logic [$clog2(`SHIM_LANES):0]     cnt;
    logic [`SHIM_TS_W-1:0]            ts;
  } seg_md_t;

  // ------------------------------------------------------------
  // aligned 64B segment towards the packet buffer
  // ------------------------------------------------------------

  // lane 0 always holds the first frame lane of the segment
  typedef struct packed {
    logic                                     v;
    seg_md_t                                  md;
    logic [`SHIM_LANES-1:0][`SHIM_LANE_W-1:0] lanes;
  } pb_seg_t;

  // ------------------------------------------------------------
  // control to datapath decision, one per cycle
  // ------------------------------------------------------------

  typedef struct packed {
    // rotated lane i takes input lane (i + rot) mod 8
    logic [$clog2(`SHIM_LANES)-1:0]   rot;
    // update the residual register
    logic                             ld_res;
    // per-lane: take the lane from the residual register
    logic [`SHIM_LANES-1:0]           merge;
    // register a segment towards the buffer
    logic                             emit;
    // drop whatever the residual register holds
    logic                             clr;
    seg_md_t                          md;
  } seg_sel_t;

endpackage

//--- epl_shim/epl_shim.sv
// ingress shim top: stage-1 capture registers and per-port control and segment datapath
`timescale 1ns/1ns
`include "shim_defines.svh"

module epl_shim (
  input  logic                                      cclk,
  input  logic                                      rst,
  input  shim_epl_pkg::epl_in_t [`SHIM_PORTS-1:0]   i_epl,
  output shim_pb_pkg::pb_seg_t  [`SHIM_PORTS-1:0]   o_pb
);

  // word in at T, s1 capture at T+1, select at T+2, segment at T+3

  for (genvar p = 0; p < `SHIM_PORTS; p++) begin : g_port

    logic                                       s1_v;
    shim_epl_pkg::epl_md_t                      s1_md;
    shim_epl_pkg::epl_lane_t [`SHIM_LANES-1:0]  s1_lanes;
    shim_epl_pkg::epl_lane_t [`SHIM_LANES-1:0]  s2_lanes;
    shim_pb_pkg::seg_sel_t                      sel;

    // ------------------------------------------------------------
    // stage 1 capture
    // ------------------------------------------------------------

    always_ff @(posedge cclk) begin
      if (rst) begin
        s1_v <= 1'b0;
      end else begin
        s1_v <= i_epl[p].v;
      end
    end

    // metadata and lanes only move on a valid word
    always_ff @(posedge cclk) begin
      if (i_epl[p].v) begin
        s1_md    <= i_epl[p].md;
        s1_lanes <= i_epl[p].lanes;
      end
    end

    // lanes wait one cycle so they meet the control decision
    always_ff @(posedge cclk) begin
      if (s1_v) begin
        s2_lanes <= s1_lanes;
      end
    end

    // ------------------------------------------------------------
    // control and datapath pair
    // ------------------------------------------------------------

    shim_ctrl ctrl_i (
      .cclk  (cclk),
      .rst   (rst),
      .i_v   (s1_v),
      .i_md  (s1_md),
      .o_sel (sel)
    );

    shim_segs segs_i (
      .cclk    (cclk),
      .rst     (rst),
      .i_lanes (s2_lanes),
      .i_sel   (sel),
      .o_seg   (o_pb[p])
    );

  end

endmodule

//--- epl_shim/shim_ctrl.sv
// per-port frame tracking and rotate, merge, emit and flush decisions
`timescale 1ns/1ns
`include "shim_defines.svh"

module shim_ctrl (
  input  logic                  cclk,
  input  logic                  rst,
  input  logic                  i_v,
  input  shim_epl_pkg::epl_md_t i_md,
  output shim_pb_pkg::seg_sel_t o_sel
);

  localparam int LANES = `SHIM_LANES;
  localparam int IW    = $clog2(LANES);
  localparam int CW    = IW + 1;

  // frame state
  logic                   in_frame;
  logic                   first_pend;
  logic                   flush_pend;
  logic [IW-1:0]          offset;
  logic [IW-1:0]          res_cnt;
  logic [`SHIM_TS_W-1:0]  ts_q;

  // per-word decode
  logic                   sop_w;
  logic                   active;
  logic                   eop_w;
  logic [IW-1:0]          first_lane;
  logic [IW-1:0]          last_lane;
  logic [IW-1:0]          rot;
  logic [CW-1:0]          n_lanes;
  logic [CW-1:0]          rc_eff;
  logic [CW-1:0]          total;
  logic                   fits;
  logic                   full;
  logic [CW-1:0]          keep_cnt;
  logic [LANES-1:0]       keep;

  shim_pb_pkg::seg_sel_t  sel_d;

  // ------------------------------------------------------------
  // word decode
  // ------------------------------------------------------------

  // a start word opens a frame, anything else needs one open
  assign sop_w  = i_v & i_md.sop;
  assign active = sop_w | (i_v & in_frame);
  assign eop_w  = active & i_md.eop;

  // frame lanes of this word run from first_lane to last_lane
  assign first_lane = sop_w ? i_md.sop_lane : '0;
  assign last_lane  = i_md.eop ? i_md.eop_lane : IW'(LANES - 1);
  assign n_lanes    = CW'(last_lane) - CW'(first_lane) + CW'(1);

  // residual is empty on a start word
  assign rc_eff = sop_w ? '0 : CW'(res_cnt);
  assign total  = rc_eff + n_lanes;
  assign fits   = (total <= CW'(LANES));
  assign full   = (total >= CW'(LANES));

  // rotation is fixed for the whole frame once the start lane is known
  assign rot = sop_w ? i_md.sop_lane : offset;

  // lanes below keep_cnt come out of the residual register
  assign keep_cnt = flush_pend ? CW'(res_cnt) : rc_eff;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      keep[i] = (CW'(i) < keep_cnt);
    end
  end

  // ------------------------------------------------------------
  // next decision
  // ------------------------------------------------------------

  always_comb begin
    sel_d = '0;
    if (flush_pend) begin
      // idle cycle after an overflowing end word
      sel_d.merge   = keep;
      sel_d.emit    = 1'b1;
      sel_d.clr     = 1'b1;
      sel_d.md.eop  = 1'b1;
      sel_d.md.cnt  = CW'(res_cnt);
    end else if (active) begin
      sel_d.rot     = rot;
      sel_d.merge   = keep;
      sel_d.emit    = eop_w | full;
      // an end that fits leaves nothing behind
      sel_d.ld_res  = ~(eop_w & fits);
      sel_d.clr     = eop_w & fits;
      sel_d.md.eop  = eop_w & fits;
      sel_d.md.cnt  = (eop_w & fits) ? total : CW'(LANES);
      sel_d.md.sop  = sel_d.emit & (sop_w | first_pend);
      if (sel_d.md.sop) begin
        sel_d.md.ts = sop_w ? i_md.ts : ts_q;
      end
    end
  end

  // ------------------------------------------------------------
  // state update
  // ------------------------------------------------------------

  always_ff @(posedge cclk) begin
    if (rst) begin
      in_frame   <= 1'b0;
      first_pend <= 1'b0;
      flush_pend <= 1'b0;
      offset     <= '0;
      res_cnt    <= '0;
      o_sel      <= '0;
    end else begin
      o_sel      <= sel_d;
      flush_pend <= ~flush_pend & eop_w & ~fits;
      if (flush_pend) begin
        res_cnt <= '0;
      end else if (active) begin
        if (sop_w) begin
          offset <= i_md.sop_lane;
        end
        in_frame   <= ~i_md.eop;
        first_pend <= (sop_w | first_pend) & ~sel_d.emit;
        if (eop_w & fits) begin
          res_cnt <= '0;
        end else if (full) begin
          res_cnt <= IW'(total - CW'(LANES));
        end else begin
          res_cnt <= IW'(total);
        end
      end
    end
  end

  // start timestamp waits here until the first segment leaves
  always_ff @(posedge cclk) begin
    if (sop_w) begin
      ts_q <= i_md.ts;
    end
  end

endmodule

//--- epl_shim/shim_segs.sv
// per-port segment datapath: lane rotation, residual register and output segment register
`timescale 1ns/1ns
`include "shim_defines.svh"

module shim_segs (
  input  logic                                      cclk,
  input  logic                                      rst,
  input  shim_epl_pkg::epl_lane_t [`SHIM_LANES-1:0] i_lanes,
  input  shim_pb_pkg::seg_sel_t                     i_sel,
  output shim_pb_pkg::pb_seg_t                      o_seg
);

  localparam int LANES = `SHIM_LANES;
  localparam int IW    = $clog2(LANES);
  localparam int CW    = IW + 1;

  // rotated input word
  shim_epl_pkg::epl_lane_t [LANES-1:0] rot_lanes;
  // residual lanes in front, rotated word behind them
  shim_epl_pkg::epl_lane_t [LANES-1:0] merged;
  // merged with lanes past the count forced to zero
  shim_epl_pkg::epl_lane_t [LANES-1:0] trimmed;
  // frame lanes left over from earlier words, packed from lane 0
  shim_epl_pkg::epl_lane_t [LANES-1:0] res_q;

  // output segment register
  logic                                seg_v;
  shim_pb_pkg::seg_md_t                seg_md;
  shim_epl_pkg::epl_lane_t [LANES-1:0] seg_lanes;

  // ------------------------------------------------------------
  // rotate
  // ------------------------------------------------------------

  // the control picks rot so that the first unused frame lane of
  // the word lands right after the residual lanes
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rot_lanes[i] = i_lanes[IW'(i + int'(i_sel.rot))];
    end
  end

  // ------------------------------------------------------------
  // merge with residual
  // ------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      merged[i] = i_sel.merge[i] ? res_q[i] : rot_lanes[i];
    end
  end

  // short end segments carry zeros in the unused lanes
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      trimmed[i] = (CW'(i) < i_sel.md.cnt) ? merged[i] : '0;
    end
  end

  // ------------------------------------------------------------
  // residual register
  // ------------------------------------------------------------

  // after an emit the rotated word already starts with the leftover
  // lanes at lane 0, otherwise the word is appended to the residual
  always_ff @(posedge cclk) begin
    if (i_sel.clr) begin
      res_q <= '0;
    end else if (i_sel.ld_res) begin
      if (i_sel.emit) begin
        res_q <= rot_lanes;
      end else begin
        res_q <= merged;
      end
    end
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------

  always_ff @(posedge cclk) begin
    if (rst) begin
      seg_v <= 1'b0;
    end else begin
      seg_v <= i_sel.emit;
    end
  end

  // metadata comes straight from the control decision
  always_ff @(posedge cclk) begin
    if (i_sel.emit) begin
      seg_md    <= i_sel.md;
      seg_lanes <= trimmed;
    end
  end

  assign o_seg = shim_pb_pkg::pb_seg_t'{v: seg_v, md: seg_md, lanes: seg_lanes};

endmodule

//--- testbench/epl_shim_assert.sv
// concurrent assertions on segment valid, lane count and start/end pairing per port
`timescale 1ns/1ns
`include "shim_defines.svh"

module epl_shim_assert (
  input logic                                     cclk,
  input logic                                     rst,
  input shim_pb_pkg::pb_seg_t [`SHIM_PORTS-1:0]   o_pb
);

  int   fail_cnt = 0;
  logic rst_q;

  // reset seen on the previous edge, so the first unknown edge is skipped
  always_ff @(posedge cclk) begin
    rst_q <= rst;
  end

  for (genvar p = 0; p < `SHIM_PORTS; p++) begin : g_chk
    // a start segment has left and its end has not
    logic open_q;

    always_ff @(posedge cclk) begin
      if (rst) begin
        open_q <= 1'b0;
      end else if (o_pb[p].v) begin
        if (o_pb[p].md.eop) begin
          open_q <= 1'b0;
        end else if (o_pb[p].md.sop) begin
          open_q <= 1'b1;
        end
      end
    end

    a_quiet_reset: assert property (@(posedge cclk) (rst && rst_q) |-> !o_pb[p].v)
      else begin
        fail_cnt++;
        $error("port %0d: segment valid while in reset", p);
      end

    a_cnt_range: assert property (@(posedge cclk) disable iff (rst)
      o_pb[p].v |-> (o_pb[p].md.cnt >= 1 && o_pb[p].md.cnt <= `SHIM_LANES))
      else begin
        fail_cnt++;
        $error("port %0d: lane count %0d out of range", p, o_pb[p].md.cnt);
      end

    a_sop_pairing: assert property (@(posedge cclk) disable iff (rst)
      (o_pb[p].v && o_pb[p].md.sop) |-> !open_q)
      else begin
        fail_cnt++;
        $error("port %0d: start segment before the previous frame ended", p);
      end
  end

endmodule

//--- testbench/tb_epl_shim.sv
// testbench for the ingress shim: frame table, reference segmenter, checker and watchdog
`timescale 1ns/1ns
`include "shim_defines.svh"

module tb_epl_shim;

  localparam int PERIOD    = 100;
  localparam int DRIVE_DLY = 10;
  localparam int N_ROWS    = 16;

  typedef struct {
    int port;
    int sop_lane;
    int len;
    int ts;
    int gap;
    int n_seg;
  } frame_row_t;

  // ------------------------------------------------------------
  // frame table
  // ------------------------------------------------------------

  // port, start lane, length in lanes, timestamp, idle gap, expected segments
  frame_row_t rows [N_ROWS] = '{
    '{0, 0, 16, 'h1001, 2, 2}, '{0, 0,  5, 'h1002, 1, 1}, '{0, 3,  4, 'h1003, 3, 1},
    '{0, 7, 20, 'h1004, 2, 3}, '{0, 2, 10, 'h1005, 1, 2}, '{1, 1,  7, 'h2001, 1, 1},
    '{1, 2, 10, 'h2002, 2, 2}, '{1, 4, 30, 'h2003, 2, 4}, '{1, 6,  3, 'h2004, 1, 1},
    '{2, 5, 13, 'h3001, 1, 2}, '{2, 3, 40, 'h3002, 2, 5}, '{2, 6,  8, 'h3003, 1, 1},
    '{3, 7,  1, 'h4001, 1, 1}, '{3, 4, 20, 'h4002, 2, 3}, '{3, 1,  9, 'h4003, 1, 2},
    '{3, 0, 64, 'h4004, 2, 8}
  };

  logic                                     cclk = 1'b0;
  logic                                     rst  = 1'b1;
  shim_epl_pkg::epl_in_t [`SHIM_PORTS-1:0]  i_epl;
  shim_pb_pkg::pb_seg_t  [`SHIM_PORTS-1:0]  o_pb;

  shim_epl_pkg::epl_in_t word_q [`SHIM_PORTS][$];
  shim_pb_pkg::pb_seg_t  exp_q  [`SHIM_PORTS][$];
  logic [`SHIM_PORTS-1:0] port_done = '0;
  logic                   go        = 1'b0;
  int                     errors    = 0;
  int                     checks    = 0;
  int                     words_total = 0;
  longint                 limit_ns  = 0;

  always #(PERIOD / 2) cclk = ~cclk;

  epl_shim epl_shim_i (.cclk(cclk), .rst(rst), .i_epl(i_epl), .o_pb(o_pb));

  bind epl_shim epl_shim_assert epl_shim_assert_i (.cclk(cclk), .rst(rst), .o_pb(o_pb));

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [63:0] rand_lane();
    return {$urandom, $urandom};
  endfunction

  // ------------------------------------------------------------
  // reference segmenter
  // ------------------------------------------------------------

  task automatic build_frame(input int r);
    int                    p;
    int                    s;
    int                    len;
    int                    nw;
    int                    nseg;
    int                    k;
    logic [63:0]           fl [$];
    shim_epl_pkg::epl_in_t w;
    shim_pb_pkg::pb_seg_t  seg;
    p   = rows[r].port;
    s   = rows[r].sop_lane;
    len = rows[r].len;
    nw  = (s + len + 7) / 8;
    for (int i = 0; i < len; i++) begin
      fl.push_back(rand_lane());
    end
    // lanes outside the frame carry random filler
    for (int wi = 0; wi < nw; wi++) begin
      w          = '0;
      w.v        = 1'b1;
      w.md.sop   = (wi == 0);
      w.md.sop_lane = (wi == 0) ? 3'(s) : 3'd0;
      w.md.eop   = (wi == nw - 1);
      w.md.eop_lane = (wi == nw - 1) ? 3'((s + len - 1) % 8) : 3'd0;
      w.md.ts    = (wi == 0) ? rows[r].ts : $urandom;
      for (int j = 0; j < `SHIM_LANES; j++) begin
        k          = wi * 8 + j - s;
        w.lanes[j] = (k >= 0 && k < len) ? fl[k] : rand_lane();
      end
      word_q[p].push_back(w);
    end
    // first gap cycle is idle and the rest hold words outside any frame
    for (int g = 0; g < rows[r].gap; g++) begin
      w = '0;
      if (g > 0) begin
        w.v     = 1'b1;
        w.md.ts = $urandom;
        for (int j = 0; j < `SHIM_LANES; j++) begin
          w.lanes[j] = rand_lane();
        end
      end
      word_q[p].push_back(w);
    end
    // segment count from the table and frame lanes packed from lane 0
    nseg = rows[r].n_seg;
    for (int c = 0; c < nseg; c++) begin
      seg        = '0;
      seg.v      = 1'b1;
      seg.md.sop = (c == 0);
      seg.md.eop = (c == nseg - 1);
      seg.md.cnt = (c == nseg - 1) ? len - 8 * c : 8;
      seg.md.ts  = (c == 0) ? rows[r].ts : 0;
      for (int i = 0; i < `SHIM_LANES; i++) begin
        if (c * 8 + i < len) begin
          seg.lanes[i] = fl[c * 8 + i];
        end
      end
      exp_q[p].push_back(seg);
    end
    words_total += nw + rows[r].gap;
  endtask

  // ------------------------------------------------------------
  // per-port driver and monitor
  // ------------------------------------------------------------

  for (genvar p = 0; p < `SHIM_PORTS; p++) begin : g_port
    shim_epl_pkg::epl_in_t drv;
    shim_pb_pkg::pb_seg_t  exp_seg;

    assign i_epl[p] = drv;

    initial begin
      drv = '0;
      wait (go);
      while (word_q[p].size() > 0) begin
        @(posedge cclk);
        #(DRIVE_DLY);
        drv = word_q[p].pop_front();
      end
      @(posedge cclk);
      #(DRIVE_DLY);
      drv          = '0;
      port_done[p] = 1'b1;
    end

    // registered outputs are settled by the falling edge
    always @(negedge cclk) begin
      if (!rst && o_pb[p].v) begin
        if (exp_q[p].size() == 0) begin
          errors++;
          $display("port %0d produced a segment at %0t that no frame explains", p, $time);
        end else begin
          exp_seg = exp_q[p].pop_front();
          check_value($sformatf("o_pb[%0d].md.sop", p), o_pb[p].md.sop, exp_seg.md.sop);
          check_value($sformatf("o_pb[%0d].md.eop", p), o_pb[p].md.eop, exp_seg.md.eop);
          check_value($sformatf("o_pb[%0d].md.cnt", p), o_pb[p].md.cnt, exp_seg.md.cnt);
          check_value($sformatf("o_pb[%0d].md.ts", p), o_pb[p].md.ts, exp_seg.md.ts);
          check_value($sformatf("o_pb[%0d].lanes", p), o_pb[p].lanes, exp_seg.lanes);
        end
      end
    end
  end

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("watchdog expired after %0d ns, the ports never finished", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(38));
    for (int r = 0; r < N_ROWS; r++) begin
      build_frame(r);
    end
    limit_ns = longint'(words_total + 8 + 40) * PERIOD;
    repeat (8) @(posedge cclk);
    #(DRIVE_DLY);
    rst = 1'b0;
    go  = 1'b1;
    wait (port_done == '1);
    // a flush segment leaves four cycles after its end word
    repeat (6) @(posedge cclk);
    for (int p = 0; p < `SHIM_PORTS; p++) begin
      if (exp_q[p].size() != 0) begin
        errors++;
        $display("port %0d never produced %0d expected segments", p, exp_q[p].size());
      end
    end
    errors += epl_shim_i.epl_shim_assert_i.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             epl_shim_i.epl_shim_assert_i.fail_cnt);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/shim_epl_pkg.sv
common/shim_pb_pkg.sv
epl_shim/shim_ctrl.sv
epl_shim/shim_segs.sv
epl_shim/epl_shim.sv
testbench/epl_shim_assert.sv
testbench/tb_epl_shim.sv
